//--- compile.f
+incdir+source
source/scope_pkg.sv
source/cmd_byte_collector.sv
source/spi_transaction.sv
source/acq_config_regs.sv
source/trigger_capture.sv
source/frame_fifo.sv
source/cmd_sequencer.sv
source/scope_cmd_top.sv
sim/tb_scope_cmd.sv

//--- sim/tb_scope_cmd.sv
/*
 * tb_scope_cmd
 * testbench for the digitizer command processor with host, SPI and ADC models,
 * a reference reply model, an output checker and a watchdog
 */
`timescale 1ns/1ns
`include "scope_consts.svh"

module tb_scope_cmd import scope_pkg::*; ();

	localparam int N_CMDS      = 11;
	localparam int N_FRAMES    = 30;
	localparam int WATCHDOG_NS = (N_CMDS * 150 + N_FRAMES * 20) * 4;

	logic        clk, rstn;
	logic        s_tvalid, s_tready, m_tready, adc_valid;
	logic [7:0]  s_tdata;
	stream_out_t m_out;
	spi_req_t    spi_out;
	spi_rsp_t    spi_in;
	adc_frame_t  adc_frame;

	stream_out_t exp_q[$];   // expected output words
	adc_frame_t  cap_q[$];   // frames the capture should store
	logic [7:0]  exp_spi[$];
	logic [7:0]  spi_sent[$];
	logic [7:0]  spi_cs[$];
	logic [7:0]  spi_xor;

	// capture model state
	acq_state_e  mdl_state;
	logic [15:0] mdl_cnt, mdl_taken;
	sample_t     mdl_lower, mdl_upper;

	scope_cmd_top dut (.clk, .rstn, .i_s_tvalid(s_tvalid), .i_s_tdata(s_tdata),
		.o_s_tready(s_tready), .i_m_tready(m_tready), .o_m(m_out), .o_spi(spi_out),
		.i_spi(spi_in), .i_adc_valid(adc_valid), .i_adc_frame(adc_frame));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	function automatic cmd_t make_cmd(input logic [7:0] b0, b1, b2, b3, b4, b5, b6, b7);
		return {b7, b6, b5, b4, b3, b2, b1, b0};
	endfunction

	function automatic adc_frame_t make_frame(input int s0);
		adc_frame_t f;
		for (int j = 0; j < `SCOPE_SAMPLES; j++)
			f[j] = sample_t'(s0 + 7 * j);
		return f;
	endfunction

	function automatic logic [31:0] pack_pair(input sample_t hi, input sample_t lo);
		return {4'b0000, hi, 4'b0000, lo};
	endfunction

	function automatic void push_word(input logic [31:0] data, input int rem);
		stream_out_t e;
		e.valid = 1'b1;
		e.data  = data;
		e.keep  = (rem >= 4) ? 4'b1111 : 4'((1 << rem) - 1); // low bytes only
		e.last  = (rem <= 4);
		exp_q.push_back(e);
	endfunction

	// ------------------------------
	// reference model of the replies
	function automatic void ref_reply(input cmd_t c);
		int         rem;
		int         w;
		adc_frame_t f;
		logic [7:0] x;
		case (c[0])
			OP_VERSION: push_word(`SCOPE_VERSION, 4);
			OP_SPI: begin
				exp_spi.delete();
				exp_spi.push_back(c[2]);
				if (c[7] != 8'd2)
					exp_spi.push_back(c[3]);
				exp_spi.push_back(c[4]);
				x = 8'd0;
				foreach (exp_spi[i])
					x = x ^ exp_spi[i]; // model answers xor of sent bytes
				push_word({24'd0, x}, 4);
			end
			OP_SET_THRESH: begin
				mdl_lower = sample_t'($signed(c[2]));
				mdl_upper = sample_t'($signed(c[3]));
				push_word({24'd0, `SCOPE_ACK_SET}, 4);
			end
			OP_ARM: begin
				if (mdl_state != ACQ_IDLE) begin
					push_word({24'd0, `SCOPE_ACK_BUSY}, 4);
				end else begin
					mdl_cnt   = {c[5], c[4]};
					mdl_taken = 16'd0;
					mdl_state = c[1][0] ? ACQ_WAIT_LOW : ACQ_TAKE;
					push_word({24'd0, `SCOPE_ACK_OK}, 4);
				end
			end
			OP_READ_SAMPLES: begin
				rem = {c[7], c[6], c[5], c[4]};
				w   = 0;
				f   = '0;
				while (rem > 0) begin
					if (w == 0)
						f = cap_q.pop_front();
					case (w)
						0: push_word(pack_pair(f[1], f[0]), rem);
						1: push_word(pack_pair(f[3], f[2]), rem);
						default: push_word(`SCOPE_MARKER, rem);
					endcase
					rem = (rem > 4) ? rem - 4 : 0;
					w   = (w == 2) ? 0 : w + 1;
				end
			end
			default: ; // unknown opcode gets no reply
		endcase
	endfunction

	// ------------------------------
	// host and ADC drivers
	task automatic send_cmd(input cmd_t c);
		@(posedge clk);
		#1;
		for (int i = 0; i < `SCOPE_CMD_BYTES; i++) begin
			if ($urandom % 4 == 0) begin // idle gap
				s_tvalid = 1'b0;
				@(posedge clk);
				#1;
			end
			s_tvalid = 1'b1;
			s_tdata  = c[i];
			do @(posedge clk); while (!s_tready);
			#1;
		end
		s_tvalid = 1'b0;
	endtask

	task automatic wait_replies;
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic run_cmd(input cmd_t c);
		ref_reply(c);
		send_cmd(c);
		wait_replies();
	endtask

	task automatic run_spi(input cmd_t c);
		logic [7:0] cs_exp;
		cs_exp = ~(8'b1 << c[1][2:0]);
		spi_sent.delete();
		spi_cs.delete();
		spi_xor = 8'd0;
		run_cmd(c);
		check_value("spi byte count", spi_sent.size(), exp_spi.size());
		foreach (exp_spi[i]) begin
			check_value("spi byte", spi_sent[i], exp_spi[i]);
			check_value("spi chip select", spi_cs[i], cs_exp);
		end
		check_value("chip select after transfer", spi_out.cs_n, 8'hff);
	endtask

	task automatic drive_adc(input logic valid, input int s0);
		adc_frame_t f;
		f = make_frame(s0);
		@(posedge clk);
		#1;
		adc_valid = valid;
		adc_frame = f;
		if (valid) begin
			case (mdl_state)
				ACQ_WAIT_LOW: if (f[0] < mdl_lower) mdl_state = ACQ_WAIT_HIGH;
				ACQ_WAIT_HIGH: if (f[0] > mdl_upper) mdl_state = ACQ_TAKE; // not kept
				ACQ_TAKE: begin
					cap_q.push_back(f);
					mdl_taken++;
					if (mdl_taken == mdl_cnt)
						mdl_state = ACQ_IDLE;
				end
				default: ;
			endcase
		end
	endtask

	// ------------------------------
	// SPI slave, host ready and output checker
	initial begin
		wait (rstn === 1'b1);
		forever begin
			@(posedge clk);
			if (spi_out.tx_dv) begin
				spi_sent.push_back(spi_out.tx_byte);
				spi_cs.push_back(spi_out.cs_n);
				spi_xor = spi_xor ^ spi_out.tx_byte;
				#1;
				spi_in.tx_ready = 1'b0; // busy shifting
				repeat (1 + $urandom % 3) @(posedge clk);
				#1;
				spi_in.rx_byte = spi_xor;
				spi_in.rx_dv   = 1'b1;
				@(posedge clk);
				#1;
				spi_in.rx_dv = 1'b0;
			end else if (!spi_in.tx_ready && $urandom % 3 == 0) begin
				#1;
				spi_in.tx_ready = 1'b1;
			end
		end
	end

	initial begin
		wait (rstn === 1'b1);
		forever begin
			@(posedge clk);
			#1;
			m_tready = ($urandom % 4 != 0);
		end
	end

	initial begin
		stream_out_t e;
		forever begin
			@(posedge clk);
			if (rstn && m_out.valid && m_tready) begin
				if (exp_q.size() == 0) begin
					$display("Output word %h arrived at %0t ns with no reply pending",
						m_out.data, $time);
					$display("RESULT: FAIL");
					$fatal(1);
				end else begin
					e = exp_q.pop_front();
					check_value("reply data", m_out.data, e.data);
					check_value("reply keep", m_out.keep, e.keep);
					check_value("reply last", m_out.last, e.last);
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$fatal(1);
	end

	// ------------------------------
	// test sequence
	initial begin
		void'($urandom(32'h8194_8a0d));
		rstn      = 1'b0;
		s_tvalid  = 1'b0;
		s_tdata   = 8'd0;
		m_tready  = 1'b0;
		spi_in    = '0;
		adc_valid = 1'b0;
		adc_frame = '0;
		spi_xor   = 8'd0;
		mdl_state = ACQ_IDLE;
		mdl_cnt   = 16'd0;
		mdl_taken = 16'd0;
		mdl_lower = `SCOPE_LOWER_DEF;
		mdl_upper = `SCOPE_UPPER_DEF;
		repeat (4) @(posedge clk);
		#1;
		rstn = 1'b1;

		run_cmd(make_cmd(8'h09, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00));
		run_cmd(make_cmd(OP_VERSION, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00));

		run_spi(make_cmd(OP_SPI, 8'h05, 8'ha5, 8'h3c, 8'h0f, 8'h00, 8'h00, 8'h03));
		run_spi(make_cmd(OP_SPI, 8'h0a, 8'h11, 8'h22, 8'h44, 8'h00, 8'h00, 8'h02));

		// immediate capture of five frames
		run_cmd(make_cmd(OP_ARM, 8'h00, 8'h00, 8'h00, 8'd5, 8'h00, 8'h00, 8'h00));
		for (int k = 0; k < 7; k++) begin
			if ($urandom % 3 == 0)
				drive_adc(1'b0, -1);
			drive_adc(1'b1, 16 * k + 1);
		end
		drive_adc(1'b0, 0);
		run_cmd(make_cmd(OP_READ_SAMPLES, 8'h00, 8'h00, 8'h00, 8'd60, 8'h00, 8'h00, 8'h00));

		// threshold trigger with lower -20 and upper 30
		run_cmd(make_cmd(OP_SET_THRESH, 8'h00, 8'hec, 8'h1e, 8'h00, 8'h00, 8'h00, 8'h00));
		run_cmd(make_cmd(OP_ARM, 8'h01, 8'h00, 8'h00, 8'd3, 8'h00, 8'h00, 8'h00));
		drive_adc(1'b1, 0);
		drive_adc(1'b1, -5);
		drive_adc(1'b0, -100); // invalid frame ignored
		drive_adc(1'b1, 50);
		drive_adc(1'b1, -25);
		drive_adc(1'b0, 0);
		run_cmd(make_cmd(OP_ARM, 8'h00, 8'h00, 8'h00, 8'd9, 8'h00, 8'h00, 8'h00));
		drive_adc(1'b1, 12);
		drive_adc(1'b1, 30);
		drive_adc(1'b1, 31);
		drive_adc(1'b1, 100);
		drive_adc(1'b0, 300);
		drive_adc(1'b1, 110);
		drive_adc(1'b1, -40);
		drive_adc(1'b1, 120);
		drive_adc(1'b0, 0);
		run_cmd(make_cmd(OP_READ_SAMPLES, 8'h00, 8'h00, 8'h00, 8'd30, 8'h00, 8'h00, 8'h00));

		run_cmd(make_cmd(OP_VERSION, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00));
		repeat (10) @(posedge clk);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- source/scope_cmd_top.sv
/*
 * scope_cmd_top
 * digitizer command processor, byte commands in and 32-bit replies out
 */
`timescale 1ns/1ns

module scope_cmd_top import scope_pkg::*; (
	input  logic        clk,
	input  logic        rstn,
	input  logic        i_s_tvalid,
	input  logic [7:0]  i_s_tdata,
	output logic        o_s_tready,
	input  logic        i_m_tready,
	output stream_out_t o_m,
	output spi_req_t    o_spi,
	input  spi_rsp_t    i_spi,
	input  logic        i_adc_valid,
	input  adc_frame_t  i_adc_frame
);

	cmd_t       cmd;
	logic       cmd_valid, cmd_done;
	logic       spi_start, spi_done;
	logic [7:0] spi_rx;
	logic       wr_arm, wr_thresh, arm, busy;
	logic [7:0] ack;
	acq_cfg_t   cfg;
	logic       fifo_wr, fifo_rd, fifo_full, fifo_empty;
	adc_frame_t fifo_wr_frame, fifo_head;

	cmd_byte_collector u_collector (.clk, .rstn, .i_s_tvalid, .i_s_tdata, .o_s_tready,
		.o_cmd(cmd), .o_cmd_valid(cmd_valid), .i_cmd_done(cmd_done));

	cmd_sequencer u_sequencer (.clk, .rstn, .i_cmd(cmd), .i_cmd_valid(cmd_valid),
		.o_cmd_done(cmd_done), .o_spi_start(spi_start), .i_spi_done(spi_done),
		.i_spi_rx(spi_rx), .o_wr_arm(wr_arm), .o_wr_thresh(wr_thresh), .i_ack(ack),
		.i_fifo_empty(fifo_empty), .i_fifo_frame(fifo_head), .o_fifo_rd(fifo_rd),
		.o_m, .i_m_tready);

	spi_transaction u_spi (.clk, .rstn, .i_start(spi_start), .i_cmd(cmd), .o_spi, .i_spi,
		.o_done(spi_done), .o_rx_byte(spi_rx));

	acq_config_regs u_cfg (.clk, .rstn, .i_wr_arm(wr_arm), .i_wr_thresh(wr_thresh),
		.i_cmd(cmd), .i_busy(busy), .o_cfg(cfg), .o_arm(arm), .o_ack(ack));

	trigger_capture u_capture (.clk, .rstn, .i_cfg(cfg), .i_arm(arm), .i_adc_valid,
		.i_adc_frame, .i_fifo_full(fifo_full), .o_fifo_wr(fifo_wr),
		.o_fifo_frame(fifo_wr_frame), .o_busy(busy));

	frame_fifo u_fifo (.clk, .rstn, .i_wr(fifo_wr), .i_wr_frame(fifo_wr_frame),
		.i_rd(fifo_rd), .o_rd_frame(fifo_head), .o_full(fifo_full), .o_empty(fifo_empty));

endmodule

//--- source/cmd_sequencer.sv
/*
 * cmd_sequencer
 * decodes commands, builds replies and streams packed sample words
 */
`timescale 1ns/1ns
`include "scope_consts.svh"

module cmd_sequencer import scope_pkg::*; (
	input  logic        clk,
	input  logic        rstn,
	input  cmd_t        i_cmd,
	input  logic        i_cmd_valid,
	output logic        o_cmd_done,
	output logic        o_spi_start,
	input  logic        i_spi_done,
	input  logic [7:0]  i_spi_rx,
	output logic        o_wr_arm,
	output logic        o_wr_thresh,
	input  logic [7:0]  i_ack,
	input  logic        i_fifo_empty,
	input  adc_frame_t  i_fifo_frame,
	output logic        o_fifo_rd,
	output stream_out_t o_m,
	input  logic        i_m_tready
);

	seq_state_e  state;
	logic [31:0] len;     // bytes still to send
	logic [31:0] m_data;
	logic        m_valid;
	logic [1:0]  widx;    // word within frame
	adc_frame_t  frame_q;
	logic        pop;

	function automatic logic [31:0] pack2(input sample_t hi, input sample_t lo);
		return {4'b0, hi, 4'b0, lo};
	endfunction

	function automatic logic [3:0] keep_of(input logic [31:0] n);
		if (n >= 32'd4)
			return 4'b1111;
		return (4'b0001 << n[1:0]) - 4'b0001;
	endfunction

	assign pop = (state == SEQ_POP) && (len != 32'd0) && !i_fifo_empty;

	always_comb begin
		o_m.valid = m_valid;
		o_m.data  = m_data;
		o_m.keep  = keep_of(len);
		o_m.last  = (len <= 32'd4);
	end

	// ------------------------------
	// command decode and reply
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= SEQ_IDLE;
			len         <= 32'd0;
			m_data      <= 32'd0;
			m_valid     <= 1'b0;
			widx        <= 2'd0;
			o_cmd_done  <= 1'b0;
			o_spi_start <= 1'b0;
			o_wr_arm    <= 1'b0;
			o_wr_thresh <= 1'b0;
			o_fifo_rd   <= 1'b0;
		end else begin
			o_cmd_done  <= 1'b0;
			o_spi_start <= 1'b0;
			o_wr_arm    <= 1'b0;
			o_wr_thresh <= 1'b0;
			o_fifo_rd   <= 1'b0;
			case (state)
				SEQ_IDLE: if (i_cmd_valid && !o_cmd_done) begin // skip stale valid
					case (i_cmd[0])
						OP_VERSION: begin
							m_data  <= `SCOPE_VERSION;
							len     <= 32'd4;
							m_valid <= 1'b1;
							state   <= SEQ_REPLY;
						end
						OP_SPI: begin
							o_spi_start <= 1'b1;
							state       <= SEQ_SPI;
						end
						OP_ARM: begin
							o_wr_arm <= 1'b1;
							state    <= SEQ_STROBE;
						end
						OP_SET_THRESH: begin
							o_wr_thresh <= 1'b1;
							state       <= SEQ_STROBE;
						end
						OP_READ_SAMPLES: begin
							len   <= {i_cmd[7], i_cmd[6], i_cmd[5], i_cmd[4]};
							state <= SEQ_POP;
						end
						default: o_cmd_done <= 1'b1; // unknown, no reply
					endcase
				end
				SEQ_SPI: if (i_spi_done) begin
					m_data  <= {24'd0, i_spi_rx};
					len     <= 32'd4;
					m_valid <= 1'b1;
					state   <= SEQ_REPLY;
				end
				SEQ_STROBE: state <= SEQ_ACK; // ack lands this cycle
				SEQ_ACK: begin
					m_data  <= {24'd0, i_ack};
					len     <= 32'd4;
					m_valid <= 1'b1;
					state   <= SEQ_REPLY;
				end
				SEQ_REPLY: if (i_m_tready) begin
					m_valid    <= 1'b0;
					len        <= 32'd0;
					o_cmd_done <= 1'b1;
					state      <= SEQ_IDLE;
				end
				SEQ_POP: begin
					if (len == 32'd0) begin
						o_cmd_done <= 1'b1;
						state      <= SEQ_IDLE;
					end else if (pop) begin
						o_fifo_rd <= 1'b1;
						m_data    <= pack2(i_fifo_frame[1], i_fifo_frame[0]);
						m_valid   <= 1'b1;
						widx      <= 2'd0;
						state     <= SEQ_STREAM;
					end
				end
				SEQ_STREAM: if (i_m_tready) begin
					if (len <= 32'd4) begin // rest of frame dropped
						len        <= 32'd0;
						m_valid    <= 1'b0;
						o_cmd_done <= 1'b1;
						state      <= SEQ_IDLE;
					end else begin
						len  <= len - 32'd4;
						widx <= widx + 2'd1;
						case (widx)
							2'd0: m_data <= pack2(frame_q[3], frame_q[2]);
							2'd1: m_data <= `SCOPE_MARKER;
							default: begin
								m_valid <= 1'b0;
								state   <= SEQ_POP;
							end
						endcase
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			frame_q <= i_fifo_frame;
	end

endmodule

//--- source/frame_fifo.sv
/*
 * frame_fifo
 * synchronous circular FIFO of ADC frames with registered fall-through head
 */
`timescale 1ns/1ns
`include "scope_consts.svh"

module frame_fifo import scope_pkg::*; #(
	parameter int DEPTH = `SCOPE_FIFO_DEPTH // power of two
) (
	input  logic       clk,
	input  logic       rstn,
	input  logic       i_wr,
	input  adc_frame_t i_wr_frame,
	input  logic       i_rd,
	output adc_frame_t o_rd_frame,
	output logic       o_full,
	output logic       o_empty
);

	localparam int AW = $clog2(DEPTH);

	adc_frame_t    mem [DEPTH];
	logic [AW-1:0] wptr, rptr, rptr_nxt;
	logic [AW:0]   cnt;
	logic          wr_en, rd_en;

	assign wr_en    = i_wr && !o_full;
	assign rd_en    = i_rd && !o_empty;
	assign rptr_nxt = rptr + 1'b1;
	assign o_full   = (cnt == (AW+1)'(DEPTH));
	assign o_empty  = (cnt == '0);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wptr <= '0;
			rptr <= '0;
			cnt  <= '0;
		end else begin
			if (wr_en) wptr <= wptr + 1'b1;
			if (rd_en) rptr <= rptr_nxt;
			if (wr_en && !rd_en) cnt <= cnt + 1'b1;
			else if (rd_en && !wr_en) cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wptr] <= i_wr_frame;
		if (wr_en && (o_empty || (rd_en && cnt == (AW+1)'(1))))
			o_rd_frame <= i_wr_frame; // new frame becomes head
		else if (rd_en)
			o_rd_frame <= mem[rptr_nxt];
	end

endmodule

//--- source/trigger_capture.sv
/*
 * trigger_capture
 * threshold trigger FSM, writes captured ADC frames into the frame FIFO
 */
`timescale 1ns/1ns

module trigger_capture import scope_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  acq_cfg_t   i_cfg,
	input  logic       i_arm,
	input  logic       i_adc_valid,
	input  adc_frame_t i_adc_frame,
	input  logic       i_fifo_full,
	output logic       o_fifo_wr,
	output adc_frame_t o_fifo_frame,
	output logic       o_busy
);

	acq_state_e  state;
	logic [15:0] count;
	logic        take_done;
	sample_t     s0;

	assign s0        = i_adc_frame[0];
	assign take_done = (count >= i_cfg.frame_cnt) || i_fifo_full;

	assign o_busy       = (state != ACQ_IDLE);
	assign o_fifo_wr    = (state == ACQ_TAKE) && !take_done && i_adc_valid;
	assign o_fifo_frame = i_adc_frame;

	// ------------------------------
	// trigger and take sequencing
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= ACQ_IDLE;
			count <= 16'd0;
		end else begin
			case (state)
				ACQ_IDLE: if (i_arm) begin
					count <= 16'd0;
					state <= i_cfg.trig_type ? ACQ_WAIT_LOW : ACQ_TAKE;
				end
				ACQ_WAIT_LOW: begin
					if (i_adc_valid && s0 < i_cfg.lower_thresh)
						state <= ACQ_WAIT_HIGH;
				end
				ACQ_WAIT_HIGH: begin
					if (i_adc_valid && s0 > i_cfg.upper_thresh)
						state <= ACQ_TAKE; // crossing frame not stored
				end
				ACQ_TAKE: begin
					if (take_done)
						state <= ACQ_IDLE;
					else if (i_adc_valid)
						count <= count + 16'd1;
				end
				default: state <= ACQ_IDLE;
			endcase
		end
	end

endmodule

//--- source/acq_config_regs.sv
/*
 * acq_config_regs
 * trigger configuration, thresholds and arm request
 */
`timescale 1ns/1ns
`include "scope_consts.svh"

module acq_config_regs import scope_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  logic       i_wr_arm,
	input  logic       i_wr_thresh,
	input  cmd_t       i_cmd,
	input  logic       i_busy,
	output acq_cfg_t   o_cfg,
	output logic       o_arm,
	output logic [7:0] o_ack
);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_cfg.trig_type    <= 1'b0;
			o_cfg.frame_cnt    <= 16'd0;
			o_cfg.lower_thresh <= `SCOPE_LOWER_DEF;
			o_cfg.upper_thresh <= `SCOPE_UPPER_DEF;
			o_arm <= 1'b0;
			o_ack <= 8'd0;
		end else begin
			o_arm <= 1'b0;
			if (i_wr_thresh) begin
				o_cfg.lower_thresh <= {{4{i_cmd[2][7]}}, i_cmd[2]}; // sign extend
				o_cfg.upper_thresh <= {{4{i_cmd[3][7]}}, i_cmd[3]};
				o_ack <= `SCOPE_ACK_SET;
			end else if (i_wr_arm) begin
				if (!i_busy) begin
					o_cfg.trig_type <= i_cmd[1][0];
					o_cfg.frame_cnt <= {i_cmd[5], i_cmd[4]};
					o_arm <= 1'b1;
					o_ack <= `SCOPE_ACK_OK;
				end else begin
					o_ack <= `SCOPE_ACK_BUSY; // capture running, keep config
				end
			end
		end
	end

endmodule

//--- source/spi_transaction.sv
/*
 * spi_transaction
 * one chip-selected SPI exchange of two or three bytes
 */
`timescale 1ns/1ns

module spi_transaction import scope_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  logic       i_start,
	input  cmd_t       i_cmd,
	output spi_req_t   o_spi,
	input  spi_rsp_t   i_spi,
	output logic       o_done,
	output logic [7:0] o_rx_byte
);

	spi_state_e state;
	logic [1:0] idx;     // 0..2 selects command byte 2..4
	logic [1:0] nxt_idx;
	logic       two_byte;

	assign two_byte = (i_cmd[7] == 8'd2);
	assign nxt_idx  = (idx == 2'd0 && two_byte) ? 2'd2 : idx + 2'd1; // skip byte 3

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= SPI_IDLE;
			idx         <= 2'd0;
			o_spi.tx_byte <= 8'd0;
			o_spi.tx_dv <= 1'b0;
			o_spi.cs_n  <= 8'hff;
			o_done      <= 1'b0;
			o_rx_byte   <= 8'd0;
		end else begin
			o_done <= 1'b0;
			case (state)
				SPI_IDLE: if (i_start) begin
					o_spi.cs_n[i_cmd[1][2:0]] <= 1'b0; // select chip
					o_spi.tx_byte <= i_cmd[2];
					idx   <= 2'd0;
					state <= SPI_SEND;
				end
				SPI_SEND: if (i_spi.tx_ready) begin
					o_spi.tx_dv <= 1'b1;
					state       <= SPI_STROBE;
				end
				SPI_STROBE: begin
					o_spi.tx_dv <= 1'b0;
					if (idx == 2'd2) begin
						state <= SPI_WAIT_RX;
					end else begin
						idx           <= nxt_idx;
						o_spi.tx_byte <= i_cmd[3'd2 + {1'b0, nxt_idx}];
						state         <= SPI_SEND;
					end
				end
				SPI_WAIT_RX: if (i_spi.rx_dv) begin
					o_spi.cs_n <= 8'hff; // release chip
					o_rx_byte  <= i_spi.rx_byte;
					o_done     <= 1'b1;
					state      <= SPI_IDLE;
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

endmodule

//--- source/cmd_byte_collector.sv
/*
 * cmd_byte_collector
 * gathers eight bytes of the input stream into one command
 */
`timescale 1ns/1ns
`include "scope_consts.svh"

module cmd_byte_collector import scope_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  logic       i_s_tvalid,
	input  logic [7:0] i_s_tdata,
	output logic       o_s_tready,
	output cmd_t       o_cmd,
	output logic       o_cmd_valid,
	input  logic       i_cmd_done
);

	localparam int CW = $clog2(`SCOPE_CMD_BYTES);
	localparam logic [CW-1:0] LAST_BYTE = CW'(`SCOPE_CMD_BYTES - 1);

	logic [CW-1:0] cnt;
	logic          take;

	assign take = i_s_tvalid && o_s_tready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cnt         <= '0;
			o_cmd_valid <= 1'b0;
			o_s_tready  <= 1'b0;
		end else if (o_cmd_valid) begin
			if (i_cmd_done) begin // command consumed, reopen input
				o_cmd_valid <= 1'b0;
				o_s_tready  <= 1'b1;
			end
		end else begin
			o_s_tready <= 1'b1;
			if (take) begin
				cnt <= cnt + 1'b1;
				if (cnt == LAST_BYTE) begin
					cnt         <= '0;
					o_cmd_valid <= 1'b1;
					o_s_tready  <= 1'b0; // hold until done
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			o_cmd[cnt] <= i_s_tdata;
	end

endmodule

//--- source/scope_pkg.sv
/*
 * scope_pkg
 * opcodes, state encodings and bundled signal types of the command processor
 */
`include "scope_consts.svh"

package scope_pkg;

	typedef enum logic [7:0] {
		OP_READ_SAMPLES = 8'd0,
		OP_VERSION      = 8'd2,
		OP_SPI          = 8'd3,
		OP_ARM          = 8'd5,
		OP_SET_THRESH   = 8'd7
	} cmd_opcode_e;

	typedef logic [`SCOPE_CMD_BYTES-1:0][7:0] cmd_t; // byte 0 is the opcode
	typedef logic signed [`SCOPE_SAMPLE_W-1:0] sample_t;
	typedef sample_t [`SCOPE_SAMPLES-1:0] adc_frame_t;

	typedef struct packed {
		logic        trig_type; // 1 = threshold trigger
		logic [15:0] frame_cnt;
		sample_t     lower_thresh;
		sample_t     upper_thresh;
	} acq_cfg_t;

	typedef struct packed {
		logic [7:0] tx_byte;
		logic       tx_dv;
		logic [7:0] cs_n;
	} spi_req_t;

	typedef struct packed {
		logic       tx_ready;
		logic [7:0] rx_byte;
		logic       rx_dv;
	} spi_rsp_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] data;
		logic [3:0]  keep;
		logic        last;
	} stream_out_t;

	typedef enum logic [2:0] {
		SEQ_IDLE, SEQ_SPI, SEQ_STROBE, SEQ_ACK, SEQ_REPLY, SEQ_POP, SEQ_STREAM
	} seq_state_e;
	typedef enum logic [1:0] {SPI_IDLE, SPI_SEND, SPI_STROBE, SPI_WAIT_RX} spi_state_e;
	typedef enum logic [1:0] {ACQ_IDLE, ACQ_WAIT_LOW, ACQ_WAIT_HIGH, ACQ_TAKE} acq_state_e;

endpackage

//--- source/scope_consts.svh
/*
 * scope constants
 * command length, frame geometry, FIFO depth, version, marker and reply codes
 */
`ifndef SCOPE_CONSTS_SVH
`define SCOPE_CONSTS_SVH

// ------------------------------
// command and frame geometry
`define SCOPE_CMD_BYTES   8
`define SCOPE_SAMPLES     4
`define SCOPE_SAMPLE_W    12
`define SCOPE_FIFO_DEPTH  16

// ------------------------------
// reply words and defaults
`define SCOPE_VERSION     32'd7
`define SCOPE_MARKER      32'hbeefdead
`define SCOPE_LOWER_DEF   (-12'sd10)
`define SCOPE_UPPER_DEF   (12'sd10)

`define SCOPE_ACK_OK      8'd1
`define SCOPE_ACK_BUSY    8'd0
`define SCOPE_ACK_SET     8'd2

`endif
